// ==== all.f ====
common/cpu_pkg.sv
core/alu.sv
core/fetch_unit.sv
core/decode_stage.sv
core/reg_file.sv
core/writeback_stage.sv
core/cpu_core.sv
test/tb_clock_gen.sv
test/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f all.f --top-module tb_cpu_core -o tb_cpu_core; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/tb_cpu_core 2>&1); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// ==== test/tb_cpu_core.sv ====
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam int IMEM_AW      = 14;
    localparam int RESET_CYCLES = 10;
    localparam logic [DATA_W-1:0] POISON = 16'h0200;  // Above any byte sum, below SUB wrap

    logic                   clk;
    logic                   reset;
    logic [IMEM_AW-1:0]     imem_addr;
    logic [IMEM_AW-1:0]     imem_data_addr;
    logic [DATA_W-1:0]      imem_data;
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic [DATA_W-1:0]      dmem_wdata;
    logic [DATA_W-1:0]      dmem_rdata;
    logic                   dmem_we;
    logic [DATA_W-1:0]      io_addr;
    logic [DATA_W-1:0]      io_wdata;
    logic [DATA_W-1:0]      io_rdata;
    logic                   io_read_req;
    logic                   io_write_req;
    logic [DATA_W-1:0]      pc_display;

    // Memory arrays
    logic [DATA_W-1:0] imem [1 << IMEM_AW];
    logic [DATA_W-1:0] dmem [1 << DMEM_ADDR_W];

    // DUT outputs sampled at the falling edge
    logic [IMEM_AW-1:0]     fetch_s   = '0;
    logic [DMEM_ADDR_W-1:0] daddr_s   = '0;
    logic [DATA_W-1:0]      wdata_s   = '0;
    logic [DATA_W-1:0]      ioaddr_s  = '0;
    logic                   we_s      = 1'b0;
    logic                   ioread_s  = 1'b0;
    logic                   iowrite_s = 1'b0;

    // Expected stores, {address, data}, in program order
    logic [31:0] dmem_exp [$];
    logic [31:0] io_exp [$];
    logic [31:0] dmem_head = '0;
    logic [31:0] io_head = '0;
    logic        dmem_head_ok = 1'b0;
    logic        io_head_ok = 1'b0;

    int          errors = 0;
    int          stores_seen = 0;
    int          prog_len = 0;
    int          pc = 0;          // Builder write pointer
    int          halt_pc = 0;
    int          target_pc [2];
    bit          target_hit [2];
    logic [31:0] lcg_state = 32'h758d_4dd3;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (.clk, .reset);

    cpu_core #(.IMEM_ADDR_W(IMEM_AW)) cpu_core_inst (
        .clk, .reset, .imem_addr, .imem_data, .imem_data_addr,
        .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata,
        .io_addr, .io_wdata, .io_read_req, .io_write_req, .io_rdata, .pc_display
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];  // Upper bits have the longer period
    endtask

    task automatic emit_r(input opcode_t op, input logic [3:0] rd, rs1, rs2);
        imem[pc[IMEM_AW-1:0]] = {op, rd, rs1, rs2};
        pc++;
    endtask

    task automatic emit_i(input opcode_t op, input logic [3:0] rd, input logic [7:0] imm);
        imem[pc[IMEM_AW-1:0]] = {op, rd, imm};
        pc++;
    endtask

    // Three stores of the poison value, all on the wrong path of a branch
    task automatic emit_skipped_stores();
        for (int i = 0; i < 3; i++) begin
            emit_r(OP_STORE, 4'd13, 4'd12, 4'd0);
        end
    endtask

    function automatic logic [15:0] expect_alu(input opcode_t op, input logic [15:0] a,
                                               input logic [15:0] b);
        logic [15:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            default: r = a ^ b;
        endcase
        return r;
    endfunction

    task automatic refresh_heads();
        dmem_head_ok = dmem_exp.size() > 0;
        io_head_ok   = io_exp.size() > 0;
        dmem_head    = dmem_head_ok ? dmem_exp[0] : '0;
        io_head      = io_head_ok ? io_exp[0] : '0;
    endtask

    task automatic build_program();
        logic [7:0]  a, b, m, w, x;
        logic [15:0] io_ad;
        opcode_t     op;
        for (int i = 0; i < (1 << IMEM_AW); i++) begin
            imem[i] = '0;  // NOP
        end
        for (int i = 0; i < (1 << DMEM_ADDR_W); i++) begin
            dmem[i] = 16'(i) ^ 16'h3c5a;
        end
        // ALU groups, operands forwarded from the LDI just before
        for (int k = 0; k < 10; k++) begin
            rand_byte(a);
            rand_byte(b);
            op = opcode_t'(4'(1 + k % 5));  // ADD, SUB, AND, OR, XOR in turn
            emit_i(OP_LDI, 4'd4, 8'(8'h20 + k));
            emit_i(OP_LDI, 4'd1, a);
            emit_i(OP_LDI, 4'd2, b);
            emit_r(op, 4'd3, 4'd1, 4'd2);
            emit_r(OP_STORE, 4'd3, 4'd4, 4'd0);
            dmem_exp.push_back({16'h0020 + 16'(k), expect_alu(op, {8'h00, a}, {8'h00, b})});
        end
        // Load-use
        rand_byte(w);
        rand_byte(x);
        emit_i(OP_LDI, 4'd5, 8'h40);
        emit_i(OP_LDI, 4'd8, 8'h41);
        emit_i(OP_LDI, 4'd6, w);
        emit_r(OP_STORE, 4'd6, 4'd5, 4'd0);
        emit_r(OP_LOAD, 4'd7, 4'd5, 4'd0);
        emit_i(OP_ADDI, 4'd7, x);  // Needs the load data straight from stage 3
        emit_r(OP_STORE, 4'd7, 4'd8, 4'd0);
        dmem_exp.push_back({16'h0040, 8'h00, w});
        dmem_exp.push_back({16'h0041, 16'(w) + 16'(x)});
        // I/O store, I/O load, then the loaded word to data memory
        rand_byte(x);
        rand_byte(w);
        io_ad = 16'h8000 + 16'(x);
        emit_i(OP_LDI, 4'd12, 8'h50);
        emit_i(OP_LDI, 4'd9, 8'h80);
        for (int i = 0; i < 8; i++) begin
            emit_r(OP_ADD, 4'd9, 4'd9, 4'd9);  // Doubling walks 0x80 up to 0x8000
        end
        emit_i(OP_ADDI, 4'd9, x);
        emit_i(OP_LDI, 4'd10, w);
        emit_r(OP_STORE, 4'd10, 4'd9, 4'd0);
        emit_r(OP_LOAD, 4'd11, 4'd9, 4'd0);
        emit_r(OP_STORE, 4'd11, 4'd12, 4'd0);
        io_exp.push_back({io_ad, 8'h00, w});
        dmem_exp.push_back({16'h0050, ~io_ad});
        // Poison value in R13
        emit_i(OP_LDI, 4'd13, 8'h80);
        emit_r(OP_ADD, 4'd13, 4'd13, 4'd13);
        emit_r(OP_ADD, 4'd13, 4'd13, 4'd13);
        // LDI to R15
        rand_byte(m);
        emit_i(OP_LDI, 4'd1, m);
        emit_i(OP_LDI, 4'd4, 8'h60);
        target_pc[0] = pc + 4;
        emit_i(OP_LDI, PC_REG, 8'(target_pc[0]));
        emit_skipped_stores();
        emit_r(OP_STORE, 4'd1, 4'd4, 4'd0);
        dmem_exp.push_back({16'h0060, 8'h00, m});
        // MOVZ to R15, condition holds on R0
        rand_byte(m);
        emit_i(OP_LDI, 4'd1, m);
        emit_i(OP_LDI, 4'd4, 8'h61);
        target_pc[1] = pc + 5;
        emit_i(OP_LDI, 4'd14, 8'(target_pc[1]));
        emit_r(OP_MOVZ, PC_REG, 4'd14, 4'd0);
        emit_skipped_stores();
        emit_r(OP_STORE, 4'd1, 4'd4, 4'd0);
        dmem_exp.push_back({16'h0061, 8'h00, m});
        // MOVZ to R15 with a nonzero condition register falls through
        rand_byte(m);
        rand_byte(b);
        emit_i(OP_LDI, 4'd1, m);
        emit_i(OP_LDI, 4'd4, 8'h62);
        emit_i(OP_LDI, 4'd2, b | 8'h01);
        emit_i(OP_LDI, 4'd14, 8'hf0);  // Empty area, never reached unless wrong
        emit_r(OP_MOVZ, PC_REG, 4'd14, 4'd2);
        emit_r(OP_STORE, 4'd1, 4'd4, 4'd0);
        dmem_exp.push_back({16'h0062, 8'h00, m});
        halt_pc = pc;
        emit_i(OP_LDI, PC_REG, 8'(halt_pc));  // Spins on itself
        prog_len = pc;
        refresh_heads();
    endtask

    // Every DUT output is settled by the falling edge
    always @(negedge clk) begin
        fetch_s   = imem_addr;
        we_s      = dmem_we;
        daddr_s   = dmem_addr;
        wdata_s   = dmem_wdata;
        ioaddr_s  = io_addr;
        ioread_s  = io_read_req;
        iowrite_s = io_write_req;
        for (int i = 0; i < 2; i++) begin
            if (!reset && pc_display == 16'(target_pc[i])) begin
                target_hit[i] = 1'b1;
            end
        end
    end

    // One-cycle memories and I/O controller
    always @(posedge clk) begin
        #1;
        imem_data      = imem[fetch_s];
        imem_data_addr = fetch_s;
        if (we_s) begin
            dmem[daddr_s] = wdata_s;  // Write before the read of the same edge
        end
        dmem_rdata = dmem[daddr_s];
        if (ioread_s) begin
            io_rdata = ~ioaddr_s;
        end
        if (we_s && dmem_exp.size() > 0) begin
            void'(dmem_exp.pop_front());
            stores_seen++;
        end
        if (iowrite_s && io_exp.size() > 0) begin
            void'(io_exp.pop_front());
            stores_seen++;
        end
        refresh_heads();
    end

    reset_quiet: assert property (@(negedge clk)
        (reset || $past(reset)) |-> !dmem_we && !io_read_req && !io_write_req && imem_addr == '0)
    else begin
        errors++;
        $display("Request or nonzero fetch address at %0t during or just after reset", $time);
    end

    dmem_unexpected: assert property (@(negedge clk) disable iff (reset)
        dmem_we |-> dmem_head_ok)
    else begin
        errors++;
        $display("Data memory store at %0t when none was expected", $time);
    end

    dmem_value: assert property (@(negedge clk) disable iff (reset)
        dmem_we |-> !dmem_head_ok || {1'b0, dmem_addr, dmem_wdata} == dmem_head)
    else begin
        errors++;
        $display("MISMATCH %0t data store %h <= %h, expected %h <= %h", $time,
                 dmem_addr, dmem_wdata, dmem_head[31:16], dmem_head[15:0]);
    end

    no_poison: assert property (@(negedge clk) disable iff (reset)
        dmem_we |-> dmem_wdata != POISON)
    else begin
        errors++;
        $display("MISMATCH %0t skipped instruction stored %h", $time, dmem_wdata);
    end

    io_unexpected: assert property (@(negedge clk) disable iff (reset)
        io_write_req |-> io_head_ok && !dmem_we)
    else begin
        errors++;
        $display("Unexpected I/O write, or one with dmem_we, at %0t", $time);
    end

    io_value: assert property (@(negedge clk) disable iff (reset)
        io_write_req |-> !io_head_ok || {io_addr, io_wdata} == io_head)
    else begin
        errors++;
        $display("MISMATCH %0t I/O write %h <= %h, expected %h <= %h", $time,
                 io_addr, io_wdata, io_head[31:16], io_head[15:0]);
    end

    initial begin
        imem_data      = '0;
        imem_data_addr = '0;
        dmem_rdata     = '0;
        io_rdata       = '0;
        build_program();
        wait (reset == 1'b0);
        @(negedge clk);
        while (pc_display != 16'(halt_pc)) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        stores_done: assert (dmem_exp.size() == 0 && io_exp.size() == 0)
            else begin
                errors++;
                $display("%0d data and %0d I/O stores never happened",
                         dmem_exp.size(), io_exp.size());
            end
        targets_done: assert (target_hit[0] && target_hit[1])
            else begin
                errors++;
                $display("The executing PC never reached a branch target");
            end
        $display("Report: %0d stores checked, %0d errors", stores_seen, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog, sized from the program length
    initial begin
        wait (prog_len > 0);
        repeat (RESET_CYCLES + prog_len * 4 + 100) @(posedge clk);
        $display("Run timed out before the halt loop was reached");
        $display("Report: %0d stores checked, %0d errors", stores_seen, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset drops 1 ns after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== core/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic [IMEM_ADDR_W-1:0] imem_addr,       // Stage 1 fetch address
    input  logic [DATA_W-1:0]      imem_data,
    input  logic [IMEM_ADDR_W-1:0] imem_data_addr,  // Address that imem_data came from
    output logic [DMEM_ADDR_W-1:0] dmem_addr,
    output logic [DATA_W-1:0]      dmem_wdata,
    output logic                   dmem_we,
    input  logic [DATA_W-1:0]      dmem_rdata,      // Valid in stage 3
    output logic [DATA_W-1:0]      io_addr,
    output logic [DATA_W-1:0]      io_wdata,
    output logic                   io_read_req,
    output logic                   io_write_req,
    input  logic [DATA_W-1:0]      io_rdata,        // Valid one cycle after io_read_req
    output logic [DATA_W-1:0]      pc_display
);

    // Decode to execute
    opcode_t                opcode;
    logic [REG_SEL_W-1:0]   rd, rs1, rs2;
    logic [IMM_W-1:0]       imm8;
    logic [IMEM_ADDR_W-1:0] exec_pc;

    // Register read ports
    logic [DATA_W-1:0] rd_data, rs1_data, rs2_data;

    // Execute outputs
    logic [DATA_W-1:0] result, mem_addr, store_data;
    logic              is_load, wr_en, branch_taken;

    // Writeback and branch resolution
    logic [REG_SEL_W-1:0]   wb_rd;
    logic                   wb_en;
    logic [DATA_W-1:0]      wb_data;
    logic                   redirect;
    logic [IMEM_ADDR_W-1:0] target;
    logic                   branch_taken_s2;

    fetch_unit #(.IMEM_ADDR_W(IMEM_ADDR_W)) fetch_unit_inst (
        .clk, .reset, .redirect, .target, .imem_addr
    );

    decode_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) decode_stage_inst (
        .clk, .reset, .branch_taken_s2, .imem_data, .imem_data_addr,
        .opcode, .rd, .rs1, .rs2, .imm8, .exec_pc
    );

    reg_file #(.IMEM_ADDR_W(IMEM_ADDR_W)) reg_file_inst (
        .clk, .reset, .rd, .rs1, .rs2, .exec_pc, .wb_rd, .wb_en, .wb_data,
        .rd_data, .rs1_data, .rs2_data
    );

    alu alu_inst (
        .opcode, .rd, .imm8, .rd_data, .rs1_data, .rs2_data,
        .result, .mem_addr, .is_load, .wr_en, .branch_taken,
        .dmem_we, .io_read_req, .io_write_req, .store_data
    );

    writeback_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) writeback_stage_inst (
        .clk, .reset, .is_load, .wr_en, .branch_taken, .rd, .result, .mem_addr,
        .dmem_rdata, .io_rdata, .wb_rd, .wb_en, .wb_data, .redirect, .target,
        .branch_taken_s2
    );

    // Stage 2 memory and I/O request lines share one address and data source
    assign dmem_addr  = mem_addr[DMEM_ADDR_W-1:0];  // Bit 15 only routes to I/O
    assign dmem_wdata = store_data;
    assign io_addr    = mem_addr;
    assign io_wdata   = store_data;

    assign pc_display = {{(DATA_W-IMEM_ADDR_W){1'b0}}, exec_pc};  // Executing PC

endmodule

// ==== core/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   is_load,
    input  logic                   wr_en,
    input  logic                   branch_taken,
    input  logic [REG_SEL_W-1:0]   rd,
    input  logic [DATA_W-1:0]      result,
    input  logic [DATA_W-1:0]      mem_addr,
    input  logic [DATA_W-1:0]      dmem_rdata,
    input  logic [DATA_W-1:0]      io_rdata,
    output logic [REG_SEL_W-1:0]   wb_rd,
    output logic                   wb_en,
    output logic [DATA_W-1:0]      wb_data,
    output logic                   redirect,
    output logic [IMEM_ADDR_W-1:0] target,
    output logic                   branch_taken_s2
);

    // Stage 2 to 3 control
    logic is_load_q;
    logic wr_en_q;
    logic branch_q;

    // Stage 2 to 3 payload
    logic [REG_SEL_W-1:0] rd_q;
    logic [DATA_W-1:0]    result_q;
    logic                 io_sel_q;  // Load came from the I/O side

    always_ff @(posedge clk) begin
        if (reset) begin
            is_load_q <= 1'b0;
            wr_en_q   <= 1'b0;
            branch_q  <= 1'b0;
        end else begin
            is_load_q <= is_load;
            wr_en_q   <= wr_en;
            branch_q  <= branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        rd_q     <= rd;
        result_q <= result;
        io_sel_q <= mem_addr[IO_SEL_BIT];
    end

    // Load data arrives this cycle from whichever side was addressed
    always_comb begin
        if (is_load_q) begin
            wb_data = io_sel_q ? io_rdata : dmem_rdata;
        end else begin
            wb_data = result_q;
        end
    end

    assign wb_rd = rd_q;
    assign wb_en = wr_en_q;

    // R15 writes, loads included, steer the fetch unit
    assign redirect = branch_q;
    assign target   = wb_data[IMEM_ADDR_W-1:0];

    assign branch_taken_s2 = branch_taken;  // Decode bubbles on the executing branch

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [REG_SEL_W-1:0]   rd,
    input  logic [REG_SEL_W-1:0]   rs1,
    input  logic [REG_SEL_W-1:0]   rs2,
    input  logic [IMEM_ADDR_W-1:0] exec_pc,   // Returned for R15 reads
    input  logic [REG_SEL_W-1:0]   wb_rd,
    input  logic                   wb_en,
    input  logic [DATA_W-1:0]      wb_data,   // Also the forwarding source
    output logic [DATA_W-1:0]      rd_data,
    output logic [DATA_W-1:0]      rs1_data,
    output logic [DATA_W-1:0]      rs2_data
);

    localparam int NUM_REGS = PC_REG;  // R0 to R14 are real storage

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Stage 3 writeback; a write to R15 is a branch and has no storage
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != PC_REG) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // One read port, used three times
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_SEL_W-1:0] sel);
        logic [DATA_W-1:0] value;
        if (sel == PC_REG) begin
            value = {{(DATA_W-IMEM_ADDR_W){1'b0}}, exec_pc};
        end else if (wb_en && wb_rd == sel) begin
            value = wb_data;  // Bypass the write landing this edge, load data included
        end else begin
            value = regs[sel];
        end
        return value;
    endfunction

    always_comb begin
        rd_data  = read_port(rd);   // STORE data and ADDI base
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

// ==== core/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; #(
    parameter int IMEM_ADDR_W = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   branch_taken_s2,  // Branch executing this cycle
    input  logic [DATA_W-1:0]      imem_data,
    input  logic [IMEM_ADDR_W-1:0] imem_data_addr,
    output opcode_t                opcode,
    output logic [REG_SEL_W-1:0]   rd,
    output logic [REG_SEL_W-1:0]   rs1,
    output logic [REG_SEL_W-1:0]   rs2,
    output logic [IMM_W-1:0]       imm8,
    output logic [IMEM_ADDR_W-1:0] exec_pc
);

    logic branch_d1;  // Branch seen one cycle ago
    logic bubble;

    // Two bubbles, the cycle of the branch and the one after
    assign bubble = branch_taken_s2 || branch_d1;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_d1 <= 1'b0;
            opcode    <= OP_NOP;
            rd        <= '0;
            rs1       <= '0;
            rs2       <= '0;
            imm8      <= '0;
            exec_pc   <= '0;
        end else begin
            branch_d1 <= branch_taken_s2;
            exec_pc   <= imem_data_addr;  // PC keeps moving through the bubbles
            if (bubble) begin
                // Squash the wrong-path instruction
                opcode <= OP_NOP;
                rd     <= '0;
                rs1    <= '0;
                rs2    <= '0;
                imm8   <= '0;
            end else begin
                opcode <= opcode_t'(imem_data[15:12]);
                rd     <= imem_data[11:8];
                rs1    <= imem_data[7:4];
                rs2    <= imem_data[3:0];
                imm8   <= imem_data[IMM_W-1:0];  // Shares bits with rs1/rs2
            end
        end
    end

    // A squashed slot cannot itself branch, so bubbling never runs past two
    bubble_limit: assert property (
        @(posedge clk) disable iff (reset)
        bubble ##1 bubble |=> !bubble
    ) else $error("MISMATCH %0t more than two bubbles in a row", $time);

endmodule

// ==== core/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_ADDR_W = 14
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   redirect,   // Branch resolved in stage 3
    input  logic [IMEM_ADDR_W-1:0] target,
    output logic [IMEM_ADDR_W-1:0] imem_addr
);

    logic [IMEM_ADDR_W-1:0] next_addr;  // Address to present when not redirecting

    // Target goes straight to memory so the fetch is not delayed a cycle
    assign imem_addr = redirect ? target : next_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            next_addr <= '0;
        end else if (redirect) begin
            next_addr <= target + 1'b1;  // Continue after the target
        end else begin
            next_addr <= next_addr + 1'b1;
        end
    end

    // Fetch stream resumes in sequence right after a redirect
    redirect_resume: assert property (
        @(posedge clk) disable iff (reset)
        redirect |=> imem_addr == $past(target) + 1'b1
    ) else $error("MISMATCH %0t fetch did not resume at target + 1", $time);

endmodule

// ==== core/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  opcode_t              opcode,
    input  logic [REG_SEL_W-1:0] rd,
    input  logic [IMM_W-1:0]     imm8,
    input  logic [DATA_W-1:0]    rd_data,
    input  logic [DATA_W-1:0]    rs1_data,
    input  logic [DATA_W-1:0]    rs2_data,
    output logic [DATA_W-1:0]    result,
    output logic [DATA_W-1:0]    mem_addr,
    output logic                 is_load,
    output logic                 wr_en,         // Register write, condition applied
    output logic                 branch_taken,  // Write to R15
    output logic                 dmem_we,
    output logic                 io_read_req,
    output logic                 io_write_req,
    output logic [DATA_W-1:0]    store_data
);

    logic [DATA_W-1:0] imm_ext;
    logic              writes_rd;  // Opcode has a destination
    logic              cond_met;
    logic              is_store;

    assign imm_ext  = {{(DATA_W-IMM_W){1'b0}}, imm8};
    assign mem_addr = rs1_data + rs2_data;  // Same address for LOAD and STORE

    always_comb begin
        result    = '0;
        writes_rd = 1'b1;
        cond_met  = 1'b1;
        case (opcode)
            OP_ADD:  result = rs1_data + rs2_data;
            OP_SUB:  result = rs1_data - rs2_data;
            OP_AND:  result = rs1_data & rs2_data;
            OP_OR:   result = rs1_data | rs2_data;
            OP_XOR:  result = rs1_data ^ rs2_data;
            OP_LDI:  result = imm_ext;
            OP_ADDI: result = rd_data + imm_ext;
            OP_MOVZ: begin
                result   = rs1_data;
                cond_met = (rs2_data == '0);  // Move only on zero
            end
            OP_LOAD: result = mem_addr;  // Replaced by load data in stage 3
            default: writes_rd = 1'b0;   // NOP, STORE and unused codes
        endcase
    end

    assign is_load      = (opcode == OP_LOAD);
    assign is_store     = (opcode == OP_STORE);
    assign wr_en        = writes_rd && cond_met;
    assign branch_taken = wr_en && (rd == PC_REG);

    // Address bit 15 steers the access
    assign store_data   = rd_data;
    assign dmem_we      = is_store && !mem_addr[IO_SEL_BIT];
    assign io_write_req = is_store && mem_addr[IO_SEL_BIT];
    assign io_read_req  = is_load && mem_addr[IO_SEL_BIT];

    // A store lands in exactly one place
    always_comb begin
        assert (!(dmem_we && io_write_req))
            else $error("MISMATCH %0t store sent to memory and I/O", $time);
    end

endmodule

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath widths
    localparam int DATA_W      = 16;  // Registers, ALU and data words
    localparam int REG_SEL_W   = 4;   // Register number field
    localparam int IMM_W       = 8;   // Immediate byte in the low half of the word
    localparam int DMEM_ADDR_W = 15;  // Data memory word address

    // R15 is not stored; reads give the executing PC, writes branch
    localparam logic [REG_SEL_W-1:0] PC_REG = 4'd15;

    // Top address bit picks the I/O controller over data memory
    localparam int IO_SEL_BIT = 15;

    // Instruction word: opcode | rd | rs1 | rs2, imm8 overlays rs1/rs2
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,   // rd = rs1 + rs2
        OP_SUB   = 4'd2,   // rd = rs1 - rs2
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_LDI   = 4'd8,   // rd = zero-extended imm8
        OP_ADDI  = 4'd9,   // rd = rd + imm8
        OP_MOVZ  = 4'd10,  // rd = rs1 when rs2 == 0
        OP_LOAD  = 4'd12,  // rd = mem[rs1 + rs2]
        OP_STORE = 4'd13   // mem[rs1 + rs2] = rd
    } opcode_t;

    // Unlisted codes behave as OP_NOP in the ALU

endpackage
